// File: wisc_pkg.sv
`default_nettype none

package wisc_pkg;

  typedef logic [15:0] ins_t;     // one fetched instruction word
  typedef logic [4:0]  opcode_t;  // lives in bits 15..11 of the word
  typedef logic [2:0]  reg_idx_t; // one of the eight general registers
  typedef logic [1:0]  pc_src_t;  // next-pc select seen by fetch

  // opcodes that change how decode picks a destination or a source
  localparam opcode_t op_halt  = 5'b00000;
  localparam opcode_t op_nop   = 5'b00001;
  localparam opcode_t op_j     = 5'b00100;
  localparam opcode_t op_jr    = 5'b00101;
  localparam opcode_t op_jal   = 5'b00110; // links into r7
  localparam opcode_t op_jalr  = 5'b00111; // links into r7 and reads rs
  localparam opcode_t op_store = 5'b10000; // reads the rd field in decode
  localparam opcode_t op_slbi  = 5'b10010; // shifts and loads into rs
  localparam opcode_t op_stu   = 5'b10011; // store that updates rs
  localparam opcode_t op_lbi   = 5'b11000; // loads into rs and never stalls

  localparam reg_idx_t reg_r7 = 3'd7;

  // only sequential and jump target matter here, branches count as not taken
  localparam pc_src_t pc_src_seq  = 2'b00;
  localparam pc_src_t pc_src_jump = 2'b10;

  // an empty pipe slot carries this word so no opcode compare can match it
  localparam ins_t nop_ins = {op_nop, 11'b0};

endpackage

`default_nettype wire

// File: if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ins_valid,    // the source offers a word this cycle
  input  wisc_pkg::ins_t ins,
  input  logic           stall_decode, // decode cannot hand its word on
  input  logic           flush_fetch,  // a jump sits in the ex slot
  output logic           ins_ready,
  output logic           dec_valid,
  output wisc_pkg::ins_t dec_ins
);

  logic           occupied; // a real instruction sits in decode
  logic           accept;   // handshake completes on this edge
  wisc_pkg::ins_t ins_q;    // captured word, only meaningful while occupied

  // a word can come in when the slot is empty or drains at this edge,
  // but never in the cycle a jump is flushing fetch
  assign ins_ready = ~flush_fetch & (~occupied | ~stall_decode);
  assign accept    = ins_valid & ins_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupied <= 1'b0;
    end else if (flush_fetch) begin
      occupied <= 1'b0; // the word behind the jump is dropped
    end else if (accept) begin
      occupied <= 1'b1;
    end else if (!stall_decode) begin
      occupied <= 1'b0; // decode moved on and nothing replaced it
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ins_q <= ins; // held untouched through any number of stall cycles
    end
  end

  assign dec_valid = occupied;
  // an empty slot looks like a nop to decode and to the hazard check
  assign dec_ins   = occupied ? ins_q : wisc_pkg::nop_ins;

endmodule

`default_nettype wire

// File: ins_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ins_decode (
  input  logic               dec_valid,
  input  wisc_pkg::ins_t     dec_ins,
  output wisc_pkg::opcode_t  curr_op,
  output wisc_pkg::reg_idx_t rs,
  output wisc_pkg::reg_idx_t rt,         // also the rd source field of store and stu
  output wisc_pkg::reg_idx_t dest,       // register this instruction will write
  output logic               dest_valid, // instruction has a destination at all
  output logic               reg_write   // a real instruction claims dest
);

  wisc_pkg::reg_idx_t rd_field; // r-format destination in bits 4..2

  assign curr_op  = dec_ins[15:11];
  assign rs       = dec_ins[10:8];
  assign rt       = dec_ins[7:5];
  assign rd_field = dec_ins[4:2];

  always_comb begin
    dest       = rd_field; // alu ops write the r-format field
    dest_valid = 1'b1;
    case (curr_op)
      // these three write back into their own rs
      wisc_pkg::op_lbi,
      wisc_pkg::op_slbi,
      wisc_pkg::op_stu: begin
        dest = rs;
      end
      // the link address goes to r7
      wisc_pkg::op_jal,
      wisc_pkg::op_jalr: begin
        dest = wisc_pkg::reg_r7;
      end
      // nothing written back by plain stores, plain jumps, halt and nop
      wisc_pkg::op_store,
      wisc_pkg::op_j,
      wisc_pkg::op_jr,
      wisc_pkg::op_halt,
      wisc_pkg::op_nop: begin
        dest_valid = 1'b0;
      end
      default: begin
        dest_valid = 1'b1; // any other opcode is taken as an alu op
      end
    endcase
  end

  // a bubble in decode never claims a register
  assign reg_write = dec_valid & dest_valid;

endmodule

`default_nettype wire

// File: hazard_det.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_det (
  input  wisc_pkg::ins_t     curr_ins,         // word in decode
  input  wisc_pkg::reg_idx_t rs,
  input  wisc_pkg::reg_idx_t rt,
  input  wisc_pkg::reg_idx_t rd_id_ex,         // ex slot destination
  input  wisc_pkg::reg_idx_t rs_id_ex,         // ex slot rs
  input  wisc_pkg::ins_t     ex_mem_ins,
  input  logic               ex_mem_reg_write,
  input  logic               ex_mem_valid_rd,
  input  wisc_pkg::reg_idx_t rd_ex_mem,        // mem slot destination
  input  wisc_pkg::reg_idx_t rs_ex_mem,        // mem slot rs
  input  wisc_pkg::ins_t     mem_wb_ins,
  input  logic               mem_wb_reg_write,
  input  logic               mem_wb_valid_rd,
  input  wisc_pkg::pc_src_t  pc_source,
  output logic               stall_decode,
  output logic               flush_fetch
);

  wisc_pkg::opcode_t  opcode;
  wisc_pkg::opcode_t  ex_op;
  wisc_pkg::opcode_t  mem_op;
  wisc_pkg::reg_idx_t rd_src;       // store and stu read this field in decode
  logic               reads_rd;     // decode is store or stu
  logic               reads_rs_jmp; // decode is jr or jalr
  logic               no_stall;     // decode word is exempt from stalling
  logic               rd_wr_ex;
  logic               rd_wr_mem;

  assign opcode = curr_ins[15:11];
  assign ex_op  = ex_mem_ins[15:11];
  assign mem_op = mem_wb_ins[15:11];
  assign rd_src = curr_ins[7:5];

  assign reads_rd     = (opcode == wisc_pkg::op_store) | (opcode == wisc_pkg::op_stu);
  assign reads_rs_jmp = (opcode == wisc_pkg::op_jr) | (opcode == wisc_pkg::op_jalr);
  // lbi never waits, and nop and halt read nothing
  // an empty decode slot also arrives here as a nop
  assign no_stall = (opcode == wisc_pkg::op_lbi) | (opcode == wisc_pkg::op_nop) |
                    (opcode == wisc_pkg::op_halt);

  assign rd_wr_ex  = ex_mem_reg_write & ex_mem_valid_rd; // ex slot will write its rd
  assign rd_wr_mem = mem_wb_reg_write & mem_wb_valid_rd;

  // the four stall terms against one slot ahead of decode
  function automatic logic slot_stall(input wisc_pkg::opcode_t  op,
                                      input logic               claims_rd,
                                      input wisc_pkg::reg_idx_t slot_rd,
                                      input wisc_pkg::reg_idx_t slot_rs);
    logic rs_wr;
    logic r7_wr;
    logic gen_hit;
    logic r7_hit;
    logic rsw_hit;
    logic rdr_hit;
    rs_wr = (op == wisc_pkg::op_lbi) | (op == wisc_pkg::op_slbi) | (op == wisc_pkg::op_stu);
    r7_wr = (op == wisc_pkg::op_jal) | (op == wisc_pkg::op_jalr);
    gen_hit = claims_rd & ((slot_rd == rs) | (slot_rd == rt)); // plain rs/rt conflict
    r7_hit  = r7_wr & ((rs == wisc_pkg::reg_r7) | (rt == wisc_pkg::reg_r7));
    rsw_hit = rs_wr & ((slot_rs == rs) | (slot_rs == rt));
    // jr and jalr need rs now, store and stu need their rd field now
    rdr_hit = (reads_rs_jmp & ((claims_rd & (slot_rd == rs)) | (rs_wr & (slot_rs == rs)) |
                               (r7_wr & (rs == wisc_pkg::reg_r7)))) |
              (reads_rd & ((claims_rd & (slot_rd == rd_src)) | (rs_wr & (slot_rs == rd_src)) |
                           (r7_wr & (rd_src == wisc_pkg::reg_r7))));
    return gen_hit | r7_hit | rsw_hit | rdr_hit;
  endfunction

  always_comb begin
    // ex slot conflicts give two stall cycles, mem slot conflicts one
    stall_decode = ~no_stall & (slot_stall(ex_op, rd_wr_ex, rd_id_ex, rs_id_ex) |
                                slot_stall(mem_op, rd_wr_mem, rd_ex_mem, rs_ex_mem));
  end

  assign flush_fetch = (pc_source == wisc_pkg::pc_src_jump); // jump resolved in ex

endmodule

`default_nettype wire

// File: pipe_track.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_track (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               dec_valid,
  input  wisc_pkg::ins_t     dec_ins,
  input  wisc_pkg::reg_idx_t rs,
  input  wisc_pkg::reg_idx_t dest,
  input  logic               dest_valid,
  input  logic               reg_write,
  input  logic               stall_decode,
  output wisc_pkg::reg_idx_t rd_id_ex,
  output wisc_pkg::reg_idx_t rs_id_ex,
  output wisc_pkg::ins_t     ex_mem_ins,
  output logic               ex_mem_reg_write,
  output logic               ex_mem_valid_rd,
  output wisc_pkg::reg_idx_t rd_ex_mem,
  output wisc_pkg::reg_idx_t rs_ex_mem,
  output wisc_pkg::ins_t     mem_wb_ins,
  output logic               mem_wb_reg_write,
  output logic               mem_wb_valid_rd,
  output wisc_pkg::pc_src_t  pc_source,
  output logic               retire_valid,
  output wisc_pkg::ins_t     retire_ins
);

  logic              ex_valid;  // a real instruction occupies the ex slot
  logic              mem_valid; // a real instruction occupies the mem slot
  logic              jump_ex;   // unconditional jump resolving this cycle
  logic              advance;   // decode hands its word to ex at this edge
  wisc_pkg::opcode_t ex_op;

  assign ex_op   = ex_mem_ins[15:11];
  assign jump_ex = ex_valid & ((ex_op == wisc_pkg::op_j) | (ex_op == wisc_pkg::op_jr) |
                               (ex_op == wisc_pkg::op_jal) | (ex_op == wisc_pkg::op_jalr));

  // the jump leaves ex after one cycle, so the jump select lasts exactly one cycle
  assign pc_source = jump_ex ? wisc_pkg::pc_src_jump : wisc_pkg::pc_src_seq;

  // the word behind a jump is being flushed and must never reach ex
  assign advance = dec_valid & ~stall_decode & ~jump_ex;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid         <= 1'b0;
      ex_mem_ins       <= wisc_pkg::nop_ins;
      ex_mem_reg_write <= 1'b0;
      ex_mem_valid_rd  <= 1'b0;
      mem_valid        <= 1'b0;
      mem_wb_ins       <= wisc_pkg::nop_ins;
      mem_wb_reg_write <= 1'b0;
      mem_wb_valid_rd  <= 1'b0;
    end else begin
      // a stalled or empty decode sends a bubble that matches no opcode term
      ex_valid         <= advance;
      ex_mem_ins       <= advance ? dec_ins : wisc_pkg::nop_ins;
      ex_mem_reg_write <= advance & reg_write;
      ex_mem_valid_rd  <= advance & dest_valid;
      mem_valid        <= ex_valid; // the ex slot always moves on, nothing holds it
      mem_wb_ins       <= ex_mem_ins;
      mem_wb_reg_write <= ex_mem_reg_write;
      mem_wb_valid_rd  <= ex_mem_valid_rd;
    end
  end

  // register indices only matter while the matching write flags are set
  always_ff @(posedge clk) begin
    rd_id_ex  <= dest;
    rs_id_ex  <= rs;
    rd_ex_mem <= rd_id_ex;
    rs_ex_mem <= rs_id_ex;
  end

  assign retire_valid = mem_valid; // every instruction leaves mem one cycle after entering
  assign retire_ins   = mem_wb_ins;

endmodule

`default_nettype wire

// File: pipe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ins_valid,
  input  wisc_pkg::ins_t ins,
  output logic           ins_ready,
  output logic           retire_valid,
  output wisc_pkg::ins_t retire_ins,
  output logic           stall_decode,
  output logic           flush_fetch
);

  logic               dec_valid;
  wisc_pkg::ins_t     dec_ins;
  wisc_pkg::reg_idx_t rs;
  wisc_pkg::reg_idx_t rt;
  wisc_pkg::reg_idx_t dest;
  logic               dest_valid;
  logic               reg_write;
  wisc_pkg::reg_idx_t rd_id_ex;
  wisc_pkg::reg_idx_t rs_id_ex;
  wisc_pkg::ins_t     ex_mem_ins;
  logic               ex_mem_reg_write;
  logic               ex_mem_valid_rd;
  wisc_pkg::reg_idx_t rd_ex_mem;
  wisc_pkg::reg_idx_t rs_ex_mem;
  wisc_pkg::ins_t     mem_wb_ins;
  logic               mem_wb_reg_write;
  logic               mem_wb_valid_rd;
  wisc_pkg::pc_src_t  pc_source;

  if_id_reg u_if_id (
    .clk          (clk),
    .rst_n        (rst_n),
    .ins_valid    (ins_valid),
    .ins          (ins),
    .stall_decode (stall_decode),
    .flush_fetch  (flush_fetch),
    .ins_ready    (ins_ready),
    .dec_valid    (dec_valid),
    .dec_ins      (dec_ins)
  );

  // the hazard check decodes its own opcode, so curr_op stays open here
  ins_decode u_decode (
    .dec_valid  (dec_valid),
    .dec_ins    (dec_ins),
    .curr_op    (),
    .rs         (rs),
    .rt         (rt),
    .dest       (dest),
    .dest_valid (dest_valid),
    .reg_write  (reg_write)
  );

  hazard_det u_hazard (
    .curr_ins         (dec_ins),
    .rs               (rs),
    .rt               (rt),
    .rd_id_ex         (rd_id_ex),
    .rs_id_ex         (rs_id_ex),
    .ex_mem_ins       (ex_mem_ins),
    .ex_mem_reg_write (ex_mem_reg_write),
    .ex_mem_valid_rd  (ex_mem_valid_rd),
    .rd_ex_mem        (rd_ex_mem),
    .rs_ex_mem        (rs_ex_mem),
    .mem_wb_ins       (mem_wb_ins),
    .mem_wb_reg_write (mem_wb_reg_write),
    .mem_wb_valid_rd  (mem_wb_valid_rd),
    .pc_source        (pc_source),
    .stall_decode     (stall_decode),
    .flush_fetch      (flush_fetch)
  );

  pipe_track u_track (
    .clk              (clk),
    .rst_n            (rst_n),
    .dec_valid        (dec_valid),
    .dec_ins          (dec_ins),
    .rs               (rs),
    .dest             (dest),
    .dest_valid       (dest_valid),
    .reg_write        (reg_write),
    .stall_decode     (stall_decode),
    .rd_id_ex         (rd_id_ex),
    .rs_id_ex         (rs_id_ex),
    .ex_mem_ins       (ex_mem_ins),
    .ex_mem_reg_write (ex_mem_reg_write),
    .ex_mem_valid_rd  (ex_mem_valid_rd),
    .rd_ex_mem        (rd_ex_mem),
    .rs_ex_mem        (rs_ex_mem),
    .mem_wb_ins       (mem_wb_ins),
    .mem_wb_reg_write (mem_wb_reg_write),
    .mem_wb_valid_rd  (mem_wb_valid_rd),
    .pc_source        (pc_source),
    .retire_valid     (retire_valid),
    .retire_ins       (retire_ins)
  );

endmodule

`default_nettype wire

// File: tb_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;

  localparam wisc_pkg::opcode_t op_add = 5'b11011; // decode treats any unlisted opcode as alu
  localparam int n_directed = 31;
  localparam int n_random   = 200;
  localparam int max_cycles = 4 * (n_directed + n_random + 50);

  logic           clk       = 1'b0;
  logic           rst_n     = 1'b0;
  logic           ins_valid = 1'b0;
  wisc_pkg::ins_t ins       = wisc_pkg::nop_ins;
  logic           ins_ready;
  logic           retire_valid;
  wisc_pkg::ins_t retire_ins;
  logic           stall_decode;
  logic           flush_fetch;

  // shadow decode, ex and mem slots rebuilt from the handshake alone
  logic           m_dec_v;
  logic           m_ex_v;
  logic           m_mem_v;
  wisc_pkg::ins_t m_dec;
  wisc_pkg::ins_t m_ex;
  wisc_pkg::ins_t m_mem;
  wisc_pkg::ins_t acc_q[$];          // accepted words still in flight, oldest first
  wisc_pkg::ins_t banned = 16'hffff; // word dropped behind a jump, opcode 11111 is never sent
  int             errors    = 0;
  int             stall_cnt = 0;
  int             flush_cnt = 0;
  int             stall_base = 0;
  int             flush_base = 0;
  int             cycles    = 0;

  pipe_ctrl_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ins_valid    (ins_valid),
    .ins          (ins),
    .ins_ready    (ins_ready),
    .retire_valid (retire_valid),
    .retire_ins   (retire_ins),
    .stall_decode (stall_decode),
    .flush_fetch  (flush_fetch)
  );

  always #20 clk = ~clk;

  // registers that an instruction ahead of decode is going to write
  function automatic logic [7:0] write_mask(input wisc_pkg::ins_t w);
    case (w[15:11])
      wisc_pkg::op_lbi, wisc_pkg::op_slbi, wisc_pkg::op_stu: return 8'b1 << w[10:8];
      wisc_pkg::op_jal, wisc_pkg::op_jalr: return 8'h80; // link goes to r7
      wisc_pkg::op_store, wisc_pkg::op_j, wisc_pkg::op_jr,
      wisc_pkg::op_halt, wisc_pkg::op_nop: return 8'h00;
      default: return 8'b1 << w[4:2];
    endcase
  endfunction

  // registers decode needs now, lbi never waits and nop and halt read nothing
  function automatic logic [7:0] read_mask(input wisc_pkg::ins_t w);
    case (w[15:11])
      wisc_pkg::op_lbi, wisc_pkg::op_nop, wisc_pkg::op_halt: return 8'h00;
      default: return (8'b1 << w[10:8]) | (8'b1 << w[7:5]); // rt is also the store rd field
    endcase
  endfunction

  function automatic logic is_jump(input wisc_pkg::ins_t w);
    return (w[15:11] == wisc_pkg::op_j) | (w[15:11] == wisc_pkg::op_jr) |
           (w[15:11] == wisc_pkg::op_jal) | (w[15:11] == wisc_pkg::op_jalr);
  endfunction

  function automatic wisc_pkg::ins_t alu(input wisc_pkg::reg_idx_t a, input wisc_pkg::reg_idx_t b,
                                         input wisc_pkg::reg_idx_t d);
    return {op_add, a, b, d, 2'b00};
  endfunction

  function automatic wisc_pkg::ins_t itype(input wisc_pkg::opcode_t op,
                                           input wisc_pkg::reg_idx_t a);
    return {op, a, 8'h00}; // rt bits stay zero so only r0 is read there
  endfunction

  function automatic wisc_pkg::opcode_t pick_op(input int k);
    case (k)
      0: return wisc_pkg::op_j;
      1: return wisc_pkg::op_jr;
      2: return wisc_pkg::op_jal;
      3: return wisc_pkg::op_jalr;
      4: return wisc_pkg::op_lbi;
      5: return wisc_pkg::op_slbi;
      6: return wisc_pkg::op_stu;
      7: return wisc_pkg::op_store;
      8: return wisc_pkg::op_halt;
      9: return wisc_pkg::op_nop;
      default: return op_add;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    errors++;
    $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  // outputs are compared before the edge updates anything, then the shadow slots move on
  always @(posedge clk) begin : model_step
    logic           exp_stall;
    logic           exp_flush;
    logic           exp_ready;
    wisc_pkg::ins_t front;
    if (!rst_n) begin
      m_dec_v = 1'b0;
      m_ex_v  = 1'b0;
      m_mem_v = 1'b0;
      acc_q.delete();
    end else begin
      exp_stall = m_dec_v && ((read_mask(m_dec) & ((m_ex_v ? write_mask(m_ex) : 8'h00) |
                                                   (m_mem_v ? write_mask(m_mem) : 8'h00))) != 0);
      exp_flush = m_ex_v && is_jump(m_ex); // the first checked edge also covers the reset state
      exp_ready = !exp_flush && !exp_stall;
      assert (stall_decode === exp_stall) else report_value("stall_decode", exp_stall, stall_decode);
      assert (flush_fetch === exp_flush) else report_value("flush_fetch", exp_flush, flush_fetch);
      assert (ins_ready === exp_ready) else report_value("ins_ready", exp_ready, ins_ready);
      assert (retire_valid === m_mem_v) else report_value("retire_valid", m_mem_v, retire_valid);
      stall_cnt += (stall_decode === 1'b1);
      flush_cnt += (flush_fetch === 1'b1);
      if (m_mem_v && acc_q.size() == 0) begin
        errors++;
        $display("an instruction retired at t=%0t with nothing accepted ahead of it", $time);
      end else if (m_mem_v) begin
        front = acc_q.pop_front();
        assert (retire_ins === front) else report_value("retire_ins", front, retire_ins);
        assert (retire_ins !== banned) else begin
          errors++;
          $display("word %0h flushed behind a jump retired at t=%0t", banned, $time);
        end
      end
      m_mem_v = m_ex_v;
      m_mem   = m_ex;
      m_ex_v  = m_dec_v && !exp_stall && !exp_flush; // a stall or a flush sends a bubble
      m_ex    = m_dec;
      if (exp_flush) begin
        if (m_dec_v) front = acc_q.pop_back(); // youngest accepted word is the one dropped
        m_dec_v = 1'b0;
      end else if (ins_valid && exp_ready) begin
        m_dec_v = 1'b1;
        m_dec   = ins;
        acc_q.push_back(ins);
      end else if (!exp_stall) begin
        m_dec_v = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout, the run did not finish within %0d cycles, %0d errors counted before it",
               max_cycles, errors);
      $display("Verification failed");
      $finish;
    end
  end

  // called 2 ns after an edge, returns 2 ns after the edge that took the word
  task automatic send(input wisc_pkg::ins_t w);
    ins_valid = 1'b1;
    ins       = w;
    @(posedge clk);
    while (ins_ready !== 1'b1) @(posedge clk);
    #2;
    ins_valid = 1'b0;
  endtask

  // returns 2 ns after the edge where the last accepted word retired or was dropped
  task automatic drain_pipe();
    do begin
      @(posedge clk);
      #2;
    end while (acc_q.size() != 0);
  endtask

  // waits for the pipe to empty, then checks stalls and flushes seen since the last case
  task automatic end_case(input string what, input int exp_stalls, input int exp_flushes);
    drain_pipe();
    assert (stall_cnt - stall_base == exp_stalls)
      else report_value({"stall_decode cycles in ", what}, exp_stalls, stall_cnt - stall_base);
    assert (flush_cnt - flush_base == exp_flushes)
      else report_value({"flush_fetch cycles in ", what}, exp_flushes, flush_cnt - flush_base);
    stall_base = stall_cnt;
    flush_base = flush_cnt;
  endtask

  initial begin
    logic [31:0] r;
    r = $urandom(60591);
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    send(alu(0, 1, 2));
    send(alu(3, 4, 5));
    send(alu(6, 7, 0));
    send(alu(1, 3, 4));
    end_case("independent alu ops", 0, 0);
    send(alu(0, 2, 1));
    send(alu(1, 3, 4)); // reads r1 straight behind its writer
    end_case("alu back to back", 2, 0);
    send(alu(0, 1, 2));
    send(alu(3, 4, 5));
    send(alu(6, 2, 7)); // one independent word in between
    end_case("alu with one gap", 1, 0);
    send(itype(wisc_pkg::op_lbi, 3));
    send(alu(3, 0, 5));
    end_case("lbi writing rs", 2, 0);
    send(itype(wisc_pkg::op_slbi, 4));
    send(alu(1, 4, 6));
    end_case("slbi writing rs", 2, 0);
    send(itype(wisc_pkg::op_stu, 5));
    send(alu(1, 2, 3));
    send(alu(0, 5, 4));
    end_case("stu writing rs with one gap", 1, 0);
    banned = alu(7, 1, 2);
    send(itype(wisc_pkg::op_jal, 0));
    send(banned); // only sees the jal during the single flush cycle
    end_case("jal writing r7", 1, 1);
    send(alu(0, 1, 6));
    send(itype(wisc_pkg::op_jr, 6));
    end_case("jr reading rs", 2, 1);
    send(alu(0, 1, 5));
    send(itype(wisc_pkg::op_jalr, 5));
    end_case("jalr reading rs", 2, 1);
    send(alu(0, 1, 2));
    send(alu(3, 4, 5));
    send({wisc_pkg::op_store, 3'd6, 3'd2, 5'd0}); // rd field names r2
    end_case("store rd field with one gap", 1, 0);
    send(alu(0, 1, 3));
    send({wisc_pkg::op_stu, 3'd4, 3'd3, 5'd0});
    end_case("stu rd field", 2, 0);
    send(alu(2, 4, 1));
    send(itype(wisc_pkg::op_lbi, 1));
    end_case("lbi consumer", 0, 0);
    banned = alu(1, 2, 3);
    send(itype(wisc_pkg::op_j, 0));
    send(banned);
    end_case("plain jump", 0, 1);
    banned = 16'hffff;
    for (int i = 0; i < n_random; i++) begin
      if ($urandom_range(3) == 0) begin
        @(posedge clk); // the source idles for a cycle
        #2;
      end
      r = $urandom;
      send({pick_op($urandom_range(11)), r[10:0]});
    end
    drain_pipe(); // the shadow slots already judge every random cycle
    $display("errors %0d, stall cycles %0d, flush cycles %0d, cycles run %0d",
             errors, stall_cnt, flush_cnt, cycles);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
wisc_pkg.sv
if_id_reg.sv
ins_decode.sv
hazard_det.sv
pipe_track.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv
